//--- Makefile
# Verilator build and run for the VGA framebuffer testbench.

VERILATOR ?= verilator
TOP       ?= vgafb_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) hw/*.sv hw/*.svh tests/*.sv
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides the result, not the exit status of the simulator.
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/vgafb_ctlif.sv
//--------------------
// CSR writes have no handshake; read data follows one cycle later.
// Index 10 is read only and mirrors the base in use by the fetch stage.
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "vgafb_defs.svh"

module vgafb_ctlif (
	input  wire                          sys_clk,
	input  wire                          sys_rst,
	input  wire  [13:0]                  csr_a,
	input  wire                          csr_we,
	input  wire  [31:0]                  csr_di,
	output logic [31:0]                  csr_do,
	output logic                         vga_rst,
	output vgafb_pkg::timing_cfg_t       timing,
	output logic [`VGAFB_FML_DEPTH-1:0]  baseaddress,
	input  wire                          baseaddress_ack,
	output logic [17:0]                  nbursts,
	output logic [1:0]                   vga_clk_sel
);
	localparam int AW = `VGAFB_FML_DEPTH;

	logic          csr_sel;
	logic [3:0]    csr_idx;
	logic [AW-1:0] baseaddress_act;

	// Block select on the top address bits.
	assign csr_sel = (csr_a[13:10] == 4'(`VGAFB_CSR_ADDR));
	assign csr_idx = csr_a[3:0];

	// Active base follows the request at each frame start.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			baseaddress_act <= '0;
		end else if (baseaddress_ack) begin
			baseaddress_act <= baseaddress;
		end
	end

	// Control registers.
	// Each write keeps only the field width of its register.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			vga_rst            <= 1'b1;
			timing.hres        <= 11'(`VGAFB_RST_HRES);
			timing.hsync_start <= 11'(`VGAFB_RST_HSYNC_START);
			timing.hsync_end   <= 11'(`VGAFB_RST_HSYNC_END);
			timing.hscan       <= 11'(`VGAFB_RST_HSCAN);
			timing.vres        <= 11'(`VGAFB_RST_VRES);
			timing.vsync_start <= 11'(`VGAFB_RST_VSYNC_START);
			timing.vsync_end   <= 11'(`VGAFB_RST_VSYNC_END);
			timing.vscan       <= 11'(`VGAFB_RST_VSCAN);
			baseaddress        <= '0;
			nbursts            <= 18'(`VGAFB_RST_NBURSTS);
			vga_clk_sel        <= 2'd0;
		end else if (csr_sel && csr_we) begin
			case (csr_idx)
				4'd0:  vga_rst            <= csr_di[0];
				4'd1:  timing.hres        <= csr_di[10:0];
				4'd2:  timing.hsync_start <= csr_di[10:0];
				4'd3:  timing.hsync_end   <= csr_di[10:0];
				4'd4:  timing.hscan       <= csr_di[10:0];
				4'd5:  timing.vres        <= csr_di[10:0];
				4'd6:  timing.vsync_start <= csr_di[10:0];
				4'd7:  timing.vsync_end   <= csr_di[10:0];
				4'd8:  timing.vscan       <= csr_di[10:0];
				4'd9:  baseaddress        <= csr_di[AW-1:0];
				4'd11: nbursts            <= csr_di[17:0];
				4'd12: vga_clk_sel        <= csr_di[1:0];
				default: ;
			endcase
		end
	end

	// Registered readback, zero when unselected or unused.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= 32'd0;
		end else if (!csr_sel) begin
			csr_do <= 32'd0;
		end else begin
			case (csr_idx)
				4'd0:    csr_do <= 32'(vga_rst);
				4'd1:    csr_do <= 32'(timing.hres);
				4'd2:    csr_do <= 32'(timing.hsync_start);
				4'd3:    csr_do <= 32'(timing.hsync_end);
				4'd4:    csr_do <= 32'(timing.hscan);
				4'd5:    csr_do <= 32'(timing.vres);
				4'd6:    csr_do <= 32'(timing.vsync_start);
				4'd7:    csr_do <= 32'(timing.vsync_end);
				4'd8:    csr_do <= 32'(timing.vscan);
				4'd9:    csr_do <= 32'(baseaddress);
				4'd10:   csr_do <= 32'(baseaddress_act);
				4'd11:   csr_do <= 32'(nbursts);
				4'd12:   csr_do <= 32'(vga_clk_sel);
				default: csr_do <= 32'd0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/vgafb_defs.svh
//--------------------
// Reset values give 640x480 at 60 Hz with a 25 MHz pixel clock.
// Timing fields are 11 bits wide, so no value may exceed 2047.
//--------------------
`ifndef VGAFB_DEFS_SVH
`define VGAFB_DEFS_SVH

// Framebuffer byte address width.
`define VGAFB_FML_DEPTH 26
// Top four CSR address bits that select this block.
`define VGAFB_CSR_ADDR 0
// Pixels per memory burst, a power of two.
`define VGAFB_BURST_PIXELS 16

// Horizontal and vertical reset timing.
`define VGAFB_RST_HRES 640
`define VGAFB_RST_HSYNC_START 656
`define VGAFB_RST_HSYNC_END 752
`define VGAFB_RST_HSCAN 799
`define VGAFB_RST_VRES 480
`define VGAFB_RST_VSYNC_START 491
`define VGAFB_RST_VSYNC_END 493
`define VGAFB_RST_VSCAN 523
`define VGAFB_RST_NBURSTS 19200

`endif

//--- hw/vgafb_fetch.sv
//--------------------
// Memory must answer every read one cycle later; there is no stall.
// A new base takes effect only on frame_start.
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "vgafb_defs.svh"

module vgafb_fetch (
	input  wire                          sys_clk,
	input  wire                          sys_rst,
	input  wire vgafb_pkg::beam_t        beam,
	input  wire  [`VGAFB_FML_DEPTH-1:0]  baseaddress,
	input  wire  [17:0]                  nbursts,
	output logic                         baseaddress_ack,
	output logic [`VGAFB_FML_DEPTH-1:0]  mem_addr,
	output logic                         mem_re,
	output vgafb_pkg::fetch_t            pix
);
	localparam int AW = `VGAFB_FML_DEPTH;
	localparam int IW = 18 + $clog2(`VGAFB_BURST_PIXELS);

	logic [AW-1:0] frame_base;
	logic [IW-1:0] index;
	logic [IW-1:0] limit;
	logic [AW-1:0] cur_base;
	logic [IW-1:0] cur_index;
	logic          req;

	// Acknowledge at the same edge that latches the base.
	assign baseaddress_ack = beam.frame_start;

	// Pixel limit for the whole frame.
	assign limit = IW'(nbursts) * IW'(`VGAFB_BURST_PIXELS);

	// First pixel of a frame already uses the new base.
	assign cur_base  = beam.frame_start ? baseaddress : frame_base;
	assign cur_index = beam.frame_start ? '0 : index;
	assign req       = beam.active && (cur_index < limit);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			frame_base <= '0;
			index      <= '0;
			mem_re     <= 1'b0;
			pix        <= '0;
		end else begin
			frame_base <= cur_base;
			index      <= req ? cur_index + IW'(1) : cur_index;
			mem_re     <= req;
			pix.active <= beam.active;
			pix.hsync  <= beam.hsync;
			pix.vsync  <= beam.vsync;
			pix.valid  <= req;
		end
	end

	// Two bytes per RGB565 pixel.
	always_ff @(posedge sys_clk) begin
		mem_addr <= cur_base + AW'({cur_index, 1'b0});
	end

endmodule

`default_nettype wire

//--- hw/vgafb_pixel.sv
//--------------------
// Expects mem_dat one cycle after the fetch register.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module vgafb_pixel (
	input  wire                     sys_clk,
	input  wire                     sys_rst,
	input  wire vgafb_pkg::fetch_t  pix,
	input  wire  [15:0]             mem_dat,
	output logic                    vga_hsync_n,
	output logic                    vga_vsync_n,
	output vgafb_pkg::rgb_t         rgb
);
	vgafb_pkg::fetch_t pix_q;
	vgafb_pkg::rgb_t   rgb_next;

	// RGB565 to 888 with the top bits repeated into the low bits.
	always_comb begin
		rgb_next.r = {mem_dat[15:11], mem_dat[15:13]};
		rgb_next.g = {mem_dat[10:5], mem_dat[10:9]};
		rgb_next.b = {mem_dat[4:0], mem_dat[4:2]};
	end

	// Flags wait one cycle for the memory read.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pix_q       <= '0;
			vga_hsync_n <= 1'b1;
			vga_vsync_n <= 1'b1;
			rgb         <= '0;
		end else begin
			pix_q       <= pix;
			vga_hsync_n <= ~pix_q.hsync;
			vga_vsync_n <= ~pix_q.vsync;
			// Black in blanking and past the fetch limit.
			rgb         <= (pix_q.active && pix_q.valid) ? rgb_next : '0;
		end
	end

endmodule

`default_nettype wire

//--- hw/vgafb_pkg.sv
//--------------------
// Types passed between the pipeline stages.
//--------------------
`default_nettype none

package vgafb_pkg;

	// Programmed video mode, in CSR order.
	typedef struct packed {
		logic [10:0] hres;
		logic [10:0] hsync_start;
		logic [10:0] hsync_end;
		logic [10:0] hscan;
		logic [10:0] vres;
		logic [10:0] vsync_start;
		logic [10:0] vsync_end;
		logic [10:0] vscan;
	} timing_cfg_t;

	// One beam position with its decoded flags.
	typedef struct packed {
		logic [10:0] hcount;
		logic [10:0] vcount;
		logic        active;
		logic        hsync;
		logic        vsync;
		logic        frame_start;
	} beam_t;

	// Beam flags after the fetch register.
	// Valid marks a pixel that was read from memory.
	typedef struct packed {
		logic active;
		logic hsync;
		logic vsync;
		logic valid;
	} fetch_t;

	// Video output colour.
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

endpackage

`default_nettype wire

//--- hw/vgafb_timing.sv
//--------------------
// Beam position and flags come out of one register per cycle.
// A smaller scan value written mid-line wraps the counter at once.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module vgafb_timing (
	input  wire                         sys_clk,
	input  wire                         sys_rst,
	input  wire                         vga_rst,
	input  wire vgafb_pkg::timing_cfg_t timing,
	output vgafb_pkg::beam_t            beam
);
	logic             run;
	logic [10:0]      h_next;
	logic [10:0]      v_next;
	vgafb_pkg::beam_t beam_next;

	// Next beam position.
	// The first cycle after vga_rst replays 0/0 so the frame starts there.
	always_comb begin
		if (!run) begin
			h_next = 11'd0;
			v_next = 11'd0;
		end else if (beam.hcount >= timing.hscan) begin
			h_next = 11'd0;
			if (beam.vcount >= timing.vscan) begin
				v_next = 11'd0;
			end else begin
				v_next = beam.vcount + 11'd1;
			end
		end else begin
			h_next = beam.hcount + 11'd1;
			v_next = beam.vcount;
		end
	end

	// Flag decode on the next position, so flags and counters line up.
	always_comb begin
		beam_next.hcount      = h_next;
		beam_next.vcount      = v_next;
		beam_next.active      = (h_next < timing.hres) && (v_next < timing.vres);
		beam_next.hsync       = (h_next >= timing.hsync_start) &&
		                        (h_next < timing.hsync_end);
		beam_next.vsync       = (v_next >= timing.vsync_start) &&
		                        (v_next < timing.vsync_end);
		beam_next.frame_start = (h_next == 11'd0) && (v_next == 11'd0);
		// Held at zero with all flags clear while in video reset.
		if (vga_rst) begin
			beam_next = '0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			beam <= '0;
			run  <= 1'b0;
		end else begin
			beam <= beam_next;
			run  <= ~vga_rst;
		end
	end

endmodule

`default_nettype wire

//--- hw/vgafb_top.sv
//--------------------
// Memory must answer in one cycle. vga_clk_sel only leaves the chip.
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "vgafb_defs.svh"

module vgafb_top (
	input  wire                          sys_clk,
	input  wire                          sys_rst,
	input  wire  [13:0]                  csr_a,
	input  wire                          csr_we,
	input  wire  [31:0]                  csr_di,
	output wire  [31:0]                  csr_do,
	output wire  [`VGAFB_FML_DEPTH-1:0]  mem_addr,
	output wire                          mem_re,
	input  wire  [15:0]                  mem_dat,
	output wire  [1:0]                   vga_clk_sel,
	output wire                          vga_hsync_n,
	output wire                          vga_vsync_n,
	output vgafb_pkg::rgb_t              rgb
);
	wire                         vga_rst;
	wire                         baseaddress_ack;
	wire [`VGAFB_FML_DEPTH-1:0]  baseaddress;
	wire [17:0]                  nbursts;
	vgafb_pkg::timing_cfg_t      timing;
	vgafb_pkg::beam_t            beam;
	vgafb_pkg::fetch_t           pix;

	// Control registers.
	vgafb_ctlif u_ctlif (
		.sys_clk, .sys_rst, .csr_a, .csr_we, .csr_di, .csr_do,
		.vga_rst, .timing, .baseaddress, .baseaddress_ack, .nbursts, .vga_clk_sel
	);

	// Beam counters.
	vgafb_timing u_timing (
		.sys_clk, .sys_rst, .vga_rst, .timing, .beam
	);

	// Address generation.
	vgafb_fetch u_fetch (
		.sys_clk, .sys_rst, .beam, .baseaddress, .nbursts,
		.baseaddress_ack, .mem_addr, .mem_re, .pix
	);

	// Video output.
	vgafb_pixel u_pixel (
		.sys_clk, .sys_rst, .pix, .mem_dat, .vga_hsync_n, .vga_vsync_n, .rgb
	);

endmodule

`default_nettype wire

//--- sim.f
+incdir+hw
hw/vgafb_pkg.sv
hw/vgafb_ctlif.sv
hw/vgafb_timing.sv
hw/vgafb_fetch.sv
hw/vgafb_pixel.sv
hw/vgafb_top.sv
tests/vgafb_tb.sv

//--- tests/vgafb_tb.sv
//--------------------
// Runs a small 8x4 mode so frames last 104 cycles.
// Memory model answers every read one cycle later.
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "vgafb_defs.svh"

module vgafb_tb;
	// Small test mode.
	localparam int H_RES = 8;
	localparam int H_SS = 9;
	localparam int H_SE = 11;
	localparam int H_SCAN = 12;
	localparam int V_RES = 4;
	localparam int V_SS = 5;
	localparam int V_SE = 6;
	localparam int V_SCAN = 7;
	localparam int HT = H_SCAN + 1;
	localparam int FRAME = HT * (V_SCAN + 1);
	// Reset, CSR traffic, about twelve frames and a margin.
	localparam int TIMEOUT_CYCLES = 16 + 300 + 12 * FRAME + 400;

	logic                         sys_clk;
	logic                         sys_rst;
	logic [13:0]                  csr_a;
	logic                         csr_we;
	logic [31:0]                  csr_di;
	wire  [31:0]                  csr_do;
	wire  [`VGAFB_FML_DEPTH-1:0]  mem_addr;
	wire                          mem_re;
	logic [15:0]                  mem_dat;
	wire  [1:0]                   vga_clk_sel;
	wire                          vga_hsync_n;
	wire                          vga_vsync_n;
	vgafb_pkg::rgb_t              rgb;

	int errors = 0;
	int tests_ok = 0;
	int tests_bad = 0;
	int errors_at_start = 0;
	int cycles = 0;

	vgafb_top u_dut (
		.sys_clk, .sys_rst, .csr_a, .csr_we, .csr_di, .csr_do,
		.mem_addr, .mem_re, .mem_dat, .vga_clk_sel, .vga_hsync_n, .vga_vsync_n, .rgb
	);

	always #2 sys_clk = ~sys_clk;

	// Model word depends on every address bit.
	function automatic logic [15:0] mem_word(input logic [25:0] a);
		return a[15:0] ^ {6'd0, a[25:16]} ^ 16'ha5c3;
	endfunction

	// RGB565 to 888 by shifting each field up and refilling the low bits.
	function automatic logic [23:0] expand565(input logic [15:0] p);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		r = 8'(p[15:11]);
		g = 8'(p[10:5]);
		b = 8'(p[4:0]);
		r = (r << 3) | (r >> 2);
		g = (g << 2) | (g >> 4);
		b = (b << 3) | (b >> 2);
		return {r, g, b};
	endfunction

	always @(posedge sys_clk) begin
		if (mem_re) begin
			mem_dat <= #1 mem_word(mem_addr);
		end
	end

	// No colour may appear during horizontal sync.
	assert property (@(posedge sys_clk) disable iff (sys_rst)
		!vga_hsync_n |-> rgb == 24'd0)
	else begin
		errors++;
		$display("** Error: rgb during hsync = %h", rgb);
	end

	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, tests did not complete.", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("** Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	// Inputs change 1 ns after a rising edge.
	task automatic csr_write(input logic [13:0] a, input logic [31:0] d);
		@(posedge sys_clk);
		#1;
		csr_a  = a;
		csr_di = d;
		csr_we = 1'b1;
		@(posedge sys_clk);
		#1;
		csr_we = 1'b0;
	endtask

	// Read data is registered, so it is stable 1 ns after the edge.
	task automatic csr_read(input logic [13:0] a, output logic [31:0] d);
		@(posedge sys_clk);
		#1;
		csr_a  = a;
		csr_we = 1'b0;
		@(posedge sys_clk);
		#1;
		d = csr_do;
	endtask

	task automatic end_test(input string label);
		if (errors == errors_at_start) begin
			tests_ok++;
			$display("test %s: ok", label);
		end else begin
			tests_bad++;
			$display("test %s: failed with %0d errors", label, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// Find a falling edge of one sync output, sampled at negedge.
	task automatic sync_fall(input bit vert);
		logic prev;
		logic now;
		prev = 1'b0;
		forever begin
			@(negedge sys_clk);
			now = vert ? vga_vsync_n : vga_hsync_n;
			if (prev && !now) break;
			prev = now;
		end
	endtask

	// Low width and fall-to-fall period, in cycles.
	task automatic sync_measure(input bit vert, output int width, output int period);
		logic now;
		logic prev;
		sync_fall(vert);
		width = 1;
		period = 1;
		prev = 1'b0;
		forever begin
			@(negedge sys_clk);
			now = vert ? vga_vsync_n : vga_hsync_n;
			if (prev && !now) break;
			if (!now && width == period) width++;
			period++;
			prev = now;
		end
	endtask

	// Check one whole frame in raster order from output position 0/0.
	task automatic check_frame(input logic [25:0] base, input int lim);
		int idx;
		int reqs;
		logic [23:0] exp;
		logic [25:0] a;
		idx = 0;
		reqs = 0;
		sync_fall(1'b1);
		// The vsync fall marks line V_SS, column 0.
		repeat (FRAME - V_SS * HT) @(negedge sys_clk);
		for (int v = 0; v <= V_SCAN; v++) begin
			for (int h = 0; h <= H_SCAN; h++) begin
				exp = 24'd0;
				if (h < H_RES && v < V_RES) begin
					if (idx < lim) begin
						a = base + 26'(2 * idx);
						exp = expand565(mem_word(a));
					end
					idx++;
				end
				check_value("rgb", rgb, 32'(exp));
				if (mem_re) reqs++;
				@(negedge sys_clk);
			end
		end
		// Reads per frame never exceed the fetch limit.
		check_value("mem_re count", 32'(reqs), 32'((lim < idx) ? lim : idx));
	endtask

	initial begin
		logic [31:0] d;
		logic [31:0] wr [13];
		logic [31:0] mask [13];
		logic [25:0] base0;
		logic [25:0] base1;
		int w;
		int p;
		void'($urandom(32'h15fd));
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		csr_a = 14'd0;
		csr_we = 1'b0;
		csr_di = 32'd0;
		mem_dat = 16'd0;
		repeat (16) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;

		// Reset values from the defs header.
		wr[0] = 32'd1;
		wr[1] = `VGAFB_RST_HRES;
		wr[2] = `VGAFB_RST_HSYNC_START;
		wr[3] = `VGAFB_RST_HSYNC_END;
		wr[4] = `VGAFB_RST_HSCAN;
		wr[5] = `VGAFB_RST_VRES;
		wr[6] = `VGAFB_RST_VSYNC_START;
		wr[7] = `VGAFB_RST_VSYNC_END;
		wr[8] = `VGAFB_RST_VSCAN;
		wr[9] = 32'd0;
		wr[10] = 32'd0;
		wr[11] = `VGAFB_RST_NBURSTS;
		wr[12] = 32'd0;
		for (int i = 0; i < 13; i++) begin
			csr_read(14'(i), d);
			check_value($sformatf("csr_do[%0d]", i), d, wr[i]);
		end
		check_value("mem_re", 32'(mem_re), 32'd0);
		check_value("vga_hsync_n", 32'(vga_hsync_n), 32'd1);
		check_value("vga_vsync_n", 32'(vga_vsync_n), 32'd1);
		check_value("rgb", 32'(rgb), 32'd0);
		check_value("vga_clk_sel", 32'(vga_clk_sel), 32'd0);
		end_test("reset");

		// Random writes keep only the field width.
		for (int i = 1; i < 13; i++) mask[i] = 32'h7ff;
		mask[9] = 32'h3ff_ffff;
		mask[11] = 32'h3_ffff;
		mask[12] = 32'h3;
		for (int i = 1; i < 13; i++) begin
			if (i != 10) begin
				wr[i] = $urandom & mask[i];
				csr_write(14'(i), wr[i] | ~mask[i]);
				csr_read(14'(i), d);
				check_value($sformatf("csr_do[%0d]", i), d, wr[i]);
			end
		end
		// Clock select leaves the chip on its own pins.
		check_value("vga_clk_sel", 32'(vga_clk_sel), wr[12]);
		csr_write(14'd12, ~wr[12]);
		check_value("vga_clk_sel", 32'(vga_clk_sel), ~wr[12] & 32'h3);
		// Read-only index and another block address.
		csr_write(14'd10, 32'hffff_ffff);
		csr_read(14'd10, d);
		check_value("csr_do[10]", d, 32'd0);
		csr_write({4'd3, 6'd0, 4'd1}, ~wr[1]);
		csr_read(14'd1, d);
		check_value("csr_do[1]", d, wr[1]);
		csr_read(14'd13, d);
		check_value("csr_do[13]", d, 32'd0);
		csr_read({4'd3, 6'd0, 4'd1}, d);
		check_value("csr_do unselected", d, 32'd0);
		end_test("csr access");

		// Small mode, full fetch limit, random base.
		csr_write(14'd1, H_RES);
		csr_write(14'd2, H_SS);
		csr_write(14'd3, H_SE);
		csr_write(14'd4, H_SCAN);
		csr_write(14'd5, V_RES);
		csr_write(14'd6, V_SS);
		csr_write(14'd7, V_SE);
		csr_write(14'd8, V_SCAN);
		csr_write(14'd11, `VGAFB_RST_NBURSTS);
		base0 = 26'($urandom);
		csr_write(14'd9, 32'(base0));
		csr_write(14'd0, 32'd0);
		sync_measure(1'b0, w, p);
		check_value("hsync width", 32'(w), 32'(H_SE - H_SS));
		check_value("hsync period", 32'(p), 32'(HT));
		sync_measure(1'b1, w, p);
		check_value("vsync width", 32'(w), 32'((V_SE - V_SS) * HT));
		check_value("vsync period", 32'(p), 32'(FRAME));
		end_test("sync timing");

		check_frame(base0, 1 << 30);
		end_test("pixel data");

		// New base written mid-frame, inside the active lines.
		sync_fall(1'b1);
		repeat (FRAME - V_SS * HT + 2 * HT) @(negedge sys_clk);
		base1 = 26'($urandom);
		csr_write(14'd9, 32'(base1));
		csr_read(14'd10, d);
		check_value("csr_do[10]", d, 32'(base0));
		check_frame(base1, 1 << 30);
		csr_read(14'd10, d);
		check_value("csr_do[10]", d, 32'(base1));
		end_test("base handover");

		// One burst covers half of the active pixels.
		csr_write(14'd11, 32'd1);
		sync_fall(1'b1);
		check_frame(base1, `VGAFB_BURST_PIXELS);
		end_test("fetch limit");

		$display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
